// File: fpa_unit.f
+incdir+rtl
rtl/fpa_pkg.sv
rtl/fpa_cmd_queue.sv
rtl/fpa_control.sv
rtl/fpa_datapath.sv
rtl/fpa_top.sv
verif/fpa_tb.sv

// File: Bender.yml
package:
  name: fpa_unit

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/fpa_pkg.sv
      - rtl/fpa_cmd_queue.sv
      - rtl/fpa_control.sv
      - rtl/fpa_datapath.sv
      - rtl/fpa_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - verif/fpa_tb.sv

// File: verif/fpa_tb.sv
/* FPA unit testbench */

`timescale 1ns/1ps
`include "fpa_macros.svh"

module fpa_tb import fpa_pkg::*; ();

	localparam int depth      = `FPA_CMD_DEPTH;
	localparam int n_cmds     = 4 * 17 + 6 * 12 + 4 * 20 + 4 * 16;
	localparam int max_cycles = n_cmds * (`FPA_MUL_STEPS + 4) + 100;

	logic        cclk = 1'b0;
	logic        reset;
	logic        cmd_valid;
	fpa_op_t     cmd_op;
	fpa_sel_t    cmd_sel;
	logic [15:0] cmd_word;
	logic        cmd_credit;
	logic        resp_valid;
	logic [15:0] resp_word;

	// reference model, numeric bit 39 is the register MSB
	logic [39:0] t_ref;
	logic [39:0] m_ref;
	logic [39:0] c_ref;
	logic        z_ref;
	logic        neg_ref;
	logic        v_ref;
	logic        cy_ref;

	logic [15:0] lfsr = 16'd59702;
	logic [15:0] exp_words[$];
	string       exp_names[$];
	string       test_name;
	int          credits = depth;
	int          cycles = 0;

	fpa_top DUT (
		.cclk, .reset, .cmd_valid, .cmd_op, .cmd_sel, .cmd_word,
		.cmd_credit, .resp_valid, .resp_word
	);

	always #50 cclk = ~cclk;

	task automatic stop_run(input string msg);
		$display("%s", msg);
		$display("=== FAIL ===");
		$fatal(1);
	endtask

	task automatic compare(input string name, input logic [39:0] exp, input logic [39:0] act);
		if (exp !== act) begin
			$display("Mismatch in %s: expected %h, actual %h", name, exp, act);
			$display("=== FAIL ===");
			$fatal(1);
		end
	endtask

	// galois LFSR, one step per bit
	function automatic logic next_bit();
		logic b;
		b = lfsr[0];
		lfsr = lfsr >> 1;
		if (b)
			lfsr = lfsr ^ 16'hB400;
		return b;
	endfunction

	function automatic logic [39:0] rand_bits(input int n);
		logic [39:0] r;
		r = '0;
		for (int i = 0; i < n; i++)
			r = {r[38:0], next_bit()};
		return r;
	endfunction

	function automatic logic [15:0] expect_word(input fpa_sel_t sel, input logic [15:0] word);
		logic [39:0] src;
		src = word[13] ? m_ref : t_ref;
		case (sel)
			sel_w0:  return src[39:24];
			sel_w1:  return src[23:8];
			sel_w2:  return {src[7:0], 8'h00};
			default: return {z_ref, neg_ref, v_ref, cy_ref, 12'h000};
		endcase
	endfunction

	task automatic apply_model(input fpa_op_t op, input fpa_sel_t sel, input logic [15:0] word);
		logic [40:0] sum;
		logic [40:0] ssum;
		logic [79:0] prod;
		case (op)
			op_load_t: begin
				if (sel == sel_w0)
					t_ref[39:24] = word;
				else if (sel == sel_w1)
					t_ref[23:8] = word;
				else if (sel == sel_w2)
					t_ref[7:0] = word[15:8];
			end
			op_t_to_c: c_ref = t_ref;
			op_t_to_m: m_ref = t_ref;
			op_m_to_t: t_ref = m_ref;
			op_add, op_sub: begin
				// signed result on 41 bits, overflow when the top two bits differ
				if (op == op_sub) begin
					ssum = {t_ref[39], t_ref} - {c_ref[39], c_ref};
					// carry out of T + ~C + 1 means no borrow
					cy_ref = (t_ref >= c_ref);
				end else begin
					ssum = {t_ref[39], t_ref} + {c_ref[39], c_ref};
					sum = {1'b0, t_ref} + {1'b0, c_ref};
					cy_ref = sum[40];
				end
				v_ref = (ssum[40] != ssum[39]);
				t_ref = ssum[39:0];
				z_ref = (t_ref == '0);
				neg_ref = t_ref[39];
			end
			op_shl: t_ref = t_ref << 1;
			op_shr: t_ref = t_ref >> 1;
			op_mul: begin
				prod = {40'b0, c_ref} * {40'b0, m_ref};
				t_ref = prod[79:40];
				m_ref = prod[39:0];
				z_ref = (t_ref == '0);
				neg_ref = t_ref[39];
				v_ref = 1'b0;
				cy_ref = 1'b0;
			end
			op_clear: begin
				t_ref = '0;
				m_ref = '0;
			end
			op_read: begin
				exp_words.push_back(expect_word(sel, word));
				exp_names.push_back(test_name);
			end
			default: ;
		endcase
	endtask

	task automatic send_cmd(input fpa_op_t op, input fpa_sel_t sel, input logic [15:0] word);
		int gap;
		while (credits == 0) begin
			@(posedge cclk);
			#1;
		end
		cmd_valid = 1'b1;
		cmd_op = op;
		cmd_sel = sel;
		cmd_word = word;
		credits--;
		apply_model(op, sel, word);
		@(posedge cclk);
		#1;
		cmd_valid = 1'b0;
		// mostly bursts, now and then an idle gap
		gap = rand_bits(3);
		if (gap > 3)
			gap = 0;
		repeat (gap) begin
			@(posedge cclk);
			#1;
		end
	endtask

	task automatic run_op(input fpa_op_t op);
		logic [39:0] r;
		r = rand_bits(16);
		send_cmd(op, sel_w0, r[15:0]);
	endtask

	// low byte of the w2 word is junk and must be ignored
	task automatic load_t(input logic [39:0] value);
		logic [39:0] r;
		r = rand_bits(8);
		send_cmd(op_load_t, sel_w0, value[39:24]);
		send_cmd(op_load_t, sel_w1, value[23:8]);
		send_cmd(op_load_t, sel_w2, {value[7:0], r[7:0]});
	endtask

	task automatic read_reg(input logic use_m);
		send_cmd(op_read, sel_w0, use_m ? 16'h2000 : 16'h0000);
		send_cmd(op_read, sel_w1, use_m ? 16'h2000 : 16'h0000);
		send_cmd(op_read, sel_w2, use_m ? 16'h2000 : 16'h0000);
	endtask

	task automatic read_flags();
		send_cmd(op_read, sel_flags, 16'h2000);
	endtask

	// outputs sampled mid-cycle
	always @(negedge cclk) begin
		if (reset) begin
			compare("reset outputs", 40'h0, {38'h0, cmd_credit, resp_valid});
		end else begin
			if (cmd_credit) begin
				credits++;
				if (credits > depth)
					stop_run("credit returned with no command outstanding");
			end
			if (resp_valid) begin
				if (exp_words.size() == 0)
					stop_run("response arrived with no read pending");
				compare(exp_names[0], {24'h0, exp_words[0]}, {24'h0, resp_word});
				exp_words.delete(0);
				exp_names.delete(0);
			end
		end
	end

	always @(posedge cclk) begin
		cycles <= cycles + 1;
		if (cycles >= max_cycles)
			stop_run("timeout, responses still missing from the unit");
	end

	initial begin
		reset = 1'b1;
		cmd_valid = 1'b0;
		cmd_op = op_load_t;
		cmd_sel = sel_w0;
		cmd_word = '0;
		t_ref = '0;
		m_ref = '0;
		c_ref = '0;
		{z_ref, neg_ref, v_ref, cy_ref} = 4'b0000;
		repeat (5) @(posedge cclk);
		#1;
		reset = 1'b0;
		repeat (2) @(posedge cclk);
		#1;

		test_name = "load";
		for (int i = 0; i < 4; i++) begin
			load_t(rand_bits(40));
			read_reg(1'b0);
			run_op(op_t_to_m);
			load_t(rand_bits(40));
			run_op(op_m_to_t);
			read_reg(1'b0);
			read_reg(1'b1);
		end

		test_name = "addsub";
		for (int i = 0; i < 6; i++) begin
			load_t(rand_bits(40));
			run_op(op_t_to_c);
			load_t(rand_bits(40));
			if (i % 2 == 1)
				run_op(op_sub);
			else
				run_op(op_add);
			read_reg(1'b0);
			read_flags();
		end

		test_name = "shift";
		for (int i = 0; i < 4; i++) begin
			load_t(rand_bits(40));
			run_op(op_t_to_m);
			run_op(op_shl);
			read_reg(1'b0);
			run_op(op_shr);
			run_op(op_shr);
			read_reg(1'b0);
			run_op(op_clear);
			read_reg(1'b0);
			read_reg(1'b1);
		end

		test_name = "mul";
		for (int i = 0; i < 4; i++) begin
			load_t(rand_bits(40));
			run_op(op_t_to_c);
			load_t(rand_bits(40));
			run_op(op_t_to_m);
			run_op(op_mul);
			read_reg(1'b0);
			read_reg(1'b1);
			read_flags();
		end

		// last command is a read, so its response means the unit is idle
		while (exp_words.size() != 0)
			@(posedge cclk);
		repeat (5) @(posedge cclk);
		compare("idle credits", 40'(depth), 40'(credits));
		$display("=== PASS ===");
		$finish;
	end

endmodule

// File: rtl/fpa_top.sv
/* FPA arithmetic unit top */

`timescale 1ns/1ps
`include "fpa_macros.svh"

module fpa_top import fpa_pkg::*; (
	input  logic                 cclk,
	input  logic                 reset,
	input  logic                 cmd_valid,
	input  fpa_op_t              cmd_op,
	input  fpa_sel_t             cmd_sel,
	input  logic [0:`FPA_WORD-1] cmd_word,
	output logic                 cmd_credit,
	output logic                 resp_valid,
	output logic [0:`FPA_WORD-1] resp_word
);

	logic                 q_valid;
	fpa_op_t              q_op;
	fpa_sel_t             q_sel;
	logic [0:`FPA_WORD-1] q_word;
	logic                 q_pop;

	logic [1:0] k_sel;
	logic       t_load;
	logic [0:2] t_word_en;
	logic       t_shl;
	logic       t_shr;
	logic       m_load;
	logic       m_shift;
	logic       c_load;
	logic       alu_sub;
	logic       flag_en;
	logic       mul_step;
	fpa_sel_t   rd_sel;
	logic       rd_m;
	logic       rd_en;
	logic       m_lsb;

	fpa_cmd_queue u_queue (
		.cclk, .reset, .cmd_valid, .cmd_op, .cmd_sel, .cmd_word,
		.q_pop, .q_valid, .q_op, .q_sel, .q_word, .cmd_credit
	);

	fpa_control u_control (
		.cclk, .reset, .q_valid, .q_op, .q_sel, .q_word, .m_lsb,
		.q_pop, .k_sel, .t_load, .t_word_en, .t_shl, .t_shr,
		.m_load, .m_shift, .c_load, .alu_sub, .flag_en, .mul_step,
		.rd_sel, .rd_m, .rd_en, .resp_valid
	);

	// datapath latches the queue head word as its W bus
	fpa_datapath u_datapath (
		.cclk, .reset, .cmd_word(q_word), .k_sel, .t_load, .t_word_en,
		.t_shl, .t_shr, .m_load, .m_shift, .c_load, .alu_sub, .flag_en,
		.mul_step, .rd_sel, .rd_m, .rd_en, .m_lsb, .resp_word
	);

endmodule

// File: rtl/fpa_datapath.sv
/* FPA register datapath */

`timescale 1ns/1ps
`include "fpa_macros.svh"

module fpa_datapath import fpa_pkg::*; (
	input  logic                 cclk,
	input  logic                 reset,
	input  logic [0:`FPA_WORD-1] cmd_word,
	input  logic [1:0]           k_sel,
	input  logic                 t_load,
	input  logic [0:2]           t_word_en,
	input  logic                 t_shl,
	input  logic                 t_shr,
	input  logic                 m_load,
	input  logic                 m_shift,
	input  logic                 c_load,
	input  logic                 alu_sub,
	input  logic                 flag_en,
	input  logic                 mul_step,
	input  fpa_sel_t             rd_sel,
	input  logic                 rd_m,
	input  logic                 rd_en,
	output logic                 m_lsb,
	output logic [0:`FPA_WORD-1] resp_word
);

	// bit 0 is the MSB throughout
	logic [0:`FPA_WIDTH-1] t;
	logic [0:`FPA_WIDTH-1] m;
	logic [0:`FPA_WIDTH-1] c;
	logic [0:`FPA_WORD-1]  w;
	logic [0:`FPA_WIDTH-1] k;
	logic [0:`FPA_WIDTH-1] b;
	logic [0:`FPA_WIDTH]   add_res;
	logic [0:`FPA_WIDTH]   chain;
	logic [0:`FPA_WIDTH-1] t_next;
	logic                  ovf;
	logic                  z_f;
	logic                  m_f;
	logic                  v_f;
	logic                  c_f;
	logic [0:`FPA_WIDTH-1] rd_src;

	assign m_lsb = m[`FPA_WIDTH-1];

	// command word latch, holds the popped word during execution
	always_ff @(posedge cclk)
		w <= cmd_word;

	always_comb begin
		case (k_sel)
			2'd0:    k = {w, w, w[0:7]};
			2'd1:    k = add_res[1:`FPA_WIDTH];
			2'd2:    k = m;
			default: k = '0;
		endcase
	end

	// subtract as T + ~C + 1, add_res[0] is the carry out
	assign b       = alu_sub ? ~c : c;
	assign add_res = {1'b0, t} + {1'b0, b} + (`FPA_WIDTH+1)'(alu_sub);
	assign ovf     = (t[0] == b[0]) & (add_res[1] != t[0]);

	// multiply chain: carry, T and M shift right together
	assign chain = t_load ? add_res : {1'b0, t};

	always_comb begin
		t_next = t;
		if (mul_step)
			t_next = chain[0:`FPA_WIDTH-1];
		else if (t_shl)
			t_next = {t[1:`FPA_WIDTH-1], 1'b0};
		else if (t_shr)
			t_next = {1'b0, t[0:`FPA_WIDTH-2]};
		else if (t_load) begin
			if (t_word_en[0])
				t_next[0:15] = k[0:15];
			if (t_word_en[1])
				t_next[16:31] = k[16:31];
			if (t_word_en[2])
				t_next[32:`FPA_WIDTH-1] = k[32:`FPA_WIDTH-1];
		end
	end

	always_ff @(posedge cclk) begin
		if (reset) begin
			t <= '0;
			m <= '0;
			c <= '0;
		end else begin
			t <= t_next;
			if (m_shift)
				m <= {chain[`FPA_WIDTH], m[0:`FPA_WIDTH-2]};
			else if (m_load)
				m <= t_load ? k : t;
			if (c_load)
				c <= t;
		end
	end

	always_ff @(posedge cclk) begin
		if (reset) begin
			z_f <= 1'b0;
			m_f <= 1'b0;
			v_f <= 1'b0;
			c_f <= 1'b0;
		end else if (flag_en) begin
			z_f <= (t_next == '0);
			m_f <= t_next[0];
			// multiply leaves v and c clear
			v_f <= ~mul_step & ovf;
			c_f <= ~mul_step & add_res[0];
		end
	end

	assign rd_src = rd_m ? m : t;

	always_ff @(posedge cclk) begin
		if (rd_en) begin
			case (rd_sel)
				sel_w0:  resp_word <= rd_src[0:15];
				sel_w1:  resp_word <= rd_src[16:31];
				sel_w2:  resp_word <= {rd_src[32:`FPA_WIDTH-1], 8'h00};
				default: resp_word <= {z_f, m_f, v_f, c_f, 12'h000};
			endcase
		end
	end

endmodule

// File: rtl/fpa_control.sv
/* FPA command decoder and sequencer */

`timescale 1ns/1ps
`include "fpa_macros.svh"

module fpa_control import fpa_pkg::*; (
	input  logic                 cclk,
	input  logic                 reset,
	input  logic                 q_valid,
	input  fpa_op_t              q_op,
	input  fpa_sel_t             q_sel,
	input  logic [0:`FPA_WORD-1] q_word,
	input  logic                 m_lsb,
	output logic                 q_pop,
	output logic [1:0]           k_sel,
	output logic                 t_load,
	output logic [0:2]           t_word_en,
	output logic                 t_shl,
	output logic                 t_shr,
	output logic                 m_load,
	output logic                 m_shift,
	output logic                 c_load,
	output logic                 alu_sub,
	output logic                 flag_en,
	output logic                 mul_step,
	output fpa_sel_t             rd_sel,
	output logic                 rd_m,
	output logic                 rd_en,
	output logic                 resp_valid
);

	localparam int step_w = $clog2(`FPA_MUL_STEPS);

	fpa_state_t       state;
	fpa_op_t          cur_op;
	fpa_sel_t         cur_sel;
	logic             cur_rd_m;
	logic [step_w-1:0] step_cnt;
	logic             last_step;

	assign q_pop     = (state == st_idle) & q_valid;
	assign last_step = (step_cnt == step_w'(`FPA_MUL_STEPS - 1));
	assign rd_sel    = cur_sel;
	assign rd_m      = cur_rd_m;

	// k_sel: 0 cmd word, 1 adder, 2 M, 3 zero
	always_comb begin
		k_sel     = 2'd0;
		t_load    = 1'b0;
		t_word_en = 3'b000;
		t_shl     = 1'b0;
		t_shr     = 1'b0;
		m_load    = 1'b0;
		m_shift   = 1'b0;
		c_load    = 1'b0;
		alu_sub   = 1'b0;
		flag_en   = 1'b0;
		mul_step  = 1'b0;
		rd_en     = 1'b0;
		if (state == st_exec) begin
			case (cur_op)
				op_load_t: begin
					t_load = 1'b1;
					case (cur_sel)
						sel_w0:  t_word_en = 3'b100;
						sel_w1:  t_word_en = 3'b010;
						sel_w2:  t_word_en = 3'b001;
						default: t_word_en = 3'b000;
					endcase
				end
				op_t_to_c: c_load = 1'b1;
				op_t_to_m: m_load = 1'b1;
				op_m_to_t: begin
					k_sel     = 2'd2;
					t_load    = 1'b1;
					t_word_en = 3'b111;
				end
				op_add, op_sub: begin
					k_sel     = 2'd1;
					t_load    = 1'b1;
					t_word_en = 3'b111;
					alu_sub   = (cur_op == op_sub);
					flag_en   = 1'b1;
				end
				op_shl: t_shl = 1'b1;
				op_shr: t_shr = 1'b1;
				op_mul, op_clear: begin
					// zero T, and M too on clear
					k_sel     = 2'd3;
					t_load    = 1'b1;
					t_word_en = 3'b111;
					m_load    = (cur_op == op_clear);
				end
				op_read: rd_en = 1'b1;
				default: ;
			endcase
		end else if (state == st_mul) begin
			// add C only when the multiplier bit is set
			k_sel     = 2'd1;
			mul_step  = 1'b1;
			m_shift   = 1'b1;
			t_load    = m_lsb;
			t_word_en = 3'b111;
			flag_en   = last_step;
		end
	end

	always_ff @(posedge cclk) begin
		if (q_pop) begin
			cur_op   <= q_op;
			cur_sel  <= q_sel;
			cur_rd_m <= q_word[2];
		end
	end

	always_ff @(posedge cclk) begin
		if (reset) begin
			state      <= st_idle;
			step_cnt   <= '0;
			resp_valid <= 1'b0;
		end else begin
			resp_valid <= rd_en;
			case (state)
				st_idle: if (q_valid) state <= st_exec;
				st_exec: begin
					step_cnt <= '0;
					state    <= (cur_op == op_mul) ? st_mul : st_idle;
				end
				st_mul: begin
					step_cnt <= step_cnt + 1'b1;
					if (last_step)
						state <= st_idle;
				end
				default: state <= st_idle;
			endcase
		end
	end

endmodule

// File: rtl/fpa_cmd_queue.sv
/* FPA command queue */

`timescale 1ns/1ps
`include "fpa_macros.svh"

module fpa_cmd_queue import fpa_pkg::*; (
	input  logic                 cclk,
	input  logic                 reset,
	input  logic                 cmd_valid,
	input  fpa_op_t              cmd_op,
	input  fpa_sel_t             cmd_sel,
	input  logic [0:`FPA_WORD-1] cmd_word,
	input  logic                 q_pop,
	output logic                 q_valid,
	output fpa_op_t              q_op,
	output fpa_sel_t             q_sel,
	output logic [0:`FPA_WORD-1] q_word,
	output logic                 cmd_credit
);

	localparam int depth = `FPA_CMD_DEPTH;
	localparam int ptr_w = $clog2(depth);
	localparam int cnt_w = $clog2(depth + 1);

	fpa_op_t              op_mem   [depth];
	fpa_sel_t             sel_mem  [depth];
	logic [0:`FPA_WORD-1] word_mem [depth];

	logic [ptr_w-1:0] wr_ptr;
	logic [ptr_w-1:0] rd_ptr;
	logic [cnt_w-1:0] count;
	logic             do_pop;

	assign q_valid = (count != '0);
	assign do_pop  = q_pop & q_valid;

	// head of queue shown straight from storage
	assign q_op   = op_mem[rd_ptr];
	assign q_sel  = sel_mem[rd_ptr];
	assign q_word = word_mem[rd_ptr];

	always_ff @(posedge cclk) begin
		if (cmd_valid) begin
			op_mem[wr_ptr]   <= cmd_op;
			sel_mem[wr_ptr]  <= cmd_sel;
			word_mem[wr_ptr] <= cmd_word;
		end
	end

	always_ff @(posedge cclk) begin
		if (reset) begin
			wr_ptr     <= '0;
			rd_ptr     <= '0;
			count      <= '0;
			cmd_credit <= 1'b0;
		end else begin
			if (cmd_valid)
				wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
			count      <= count + cnt_w'(cmd_valid) - cnt_w'(do_pop);
			// one credit back per retired entry
			cmd_credit <= do_pop;
		end
	end

endmodule

// File: rtl/fpa_pkg.sv
/* FPA unit types */

package fpa_pkg;

	// command opcodes
	typedef enum logic [3:0] {
		op_load_t  = 4'd0,
		op_t_to_c  = 4'd1,
		op_t_to_m  = 4'd2,
		op_m_to_t  = 4'd3,
		op_add     = 4'd4,
		op_sub     = 4'd5,
		op_shl     = 4'd6,
		op_shr     = 4'd7,
		op_mul     = 4'd8,
		op_clear   = 4'd9,
		op_read    = 4'd10
	} fpa_op_t;

	// word select for T loads and the read bus
	typedef enum logic [1:0] {
		sel_w0    = 2'd0,
		sel_w1    = 2'd1,
		sel_w2    = 2'd2,
		sel_flags = 2'd3
	} fpa_sel_t;

	typedef enum logic [1:0] {
		st_idle = 2'd0,
		st_exec = 2'd1,
		st_mul  = 2'd2
	} fpa_state_t;

endpackage

// File: rtl/fpa_macros.svh
/* FPA unit widths and sizes */

`ifndef FPA_MACROS_SVH
`define FPA_MACROS_SVH

// T, M and C register width
`define FPA_WIDTH 40

// command and read bus word width
`define FPA_WORD 16

// command queue entries, also the sender's starting credits
`define FPA_CMD_DEPTH 4

// one iteration per multiplier bit
`define FPA_MUL_STEPS 40

`endif
